/* logic/fcore_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the issue front end
// Widths, queue depths and credit counts
// Instruction opcodes and ALU operation codes
// Payload types for the instruction and decoded queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fcore_pkg;

    localparam int data_width = 16;
    localparam int reg_bits = 4;
    localparam int channel_bits = 2;
    localparam int bank_addr_bits = reg_bits + channel_bits;
    localparam int instr_width = 16;
    localparam int imm_bits = 8;

    // Queue depths and the credits that go with them
    localparam int instr_credits = 4;
    localparam int decoded_depth = 2;
    localparam int issue_credits = 3;

    localparam logic [3:0] op_nop = 4'd0;
    localparam logic [3:0] op_add = 4'd1;
    localparam logic [3:0] op_sub = 4'd2;
    localparam logic [3:0] op_land = 4'd3;
    localparam logic [3:0] op_lor = 4'd4;
    localparam logic [3:0] op_lxor = 4'd5;
    localparam logic [3:0] op_bgt = 4'd6;
    localparam logic [3:0] op_beq = 4'd7;
    localparam logic [3:0] op_ldr = 4'd8;
    localparam logic [3:0] op_stop = 4'd12;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or = 3'd3,
        alu_xor = 3'd4,
        alu_cmp_gt = 3'd5,
        alu_cmp_eq = 3'd6
    } alu_op_t;

    typedef struct packed {
        logic [instr_width-1:0] word;
        logic [channel_bits-1:0] channel;
    } instr_t;

    // All register addresses are already expanded to the channel bank
    typedef struct packed {
        logic is_load;
        alu_op_t alu_op;
        logic [bank_addr_bits-1:0] addr_a;
        logic [bank_addr_bits-1:0] addr_b;
        logic [bank_addr_bits-1:0] addr_dest;
        logic [data_width-1:0] imm;
    } decoded_t;

endpackage

/* logic/credit_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular buffer queue for any payload type
// Returns one credit pulse per popped entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 2
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     pop_valid,
    output payload_t pop_data,
    output logic     credit
);

    typedef logic [$clog2(depth)-1:0] ptr_t;
    typedef logic [$clog2(depth+1)-1:0] count_t;

    payload_t mem [depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t count;
    logic do_pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A pushed entry becomes visible on the cycle after it is written
    assign pop_valid = count != '0;
    assign pop_data = mem[rd_ptr];
    assign do_pop = pop && pop_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + count_t'(push) - count_t'(do_pop);
            credit <= do_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* logic/fcore_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Splits fields, expands registers into the channel bank,
// maps opcodes to ALU operations or register loads
// Holds the decoded queue credit and the sticky stop flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_decoder (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  fcore_pkg::instr_t   instr,
    input  logic                decoded_credit,
    output logic                instr_pop,
    output logic                decoded_push,
    output fcore_pkg::decoded_t decoded,
    output logic                core_stop
);

    typedef logic [$clog2(fcore_pkg::decoded_depth+1)-1:0] count_t;

    logic [3:0] opcode;
    logic [fcore_pkg::reg_bits-1:0] reg_a;
    logic [fcore_pkg::reg_bits-1:0] reg_b;
    logic [fcore_pkg::reg_bits-1:0] reg_dest;
    logic [fcore_pkg::imm_bits-1:0] imm;
    count_t credit_count;
    logic produces;
    logic consume;
    fcore_pkg::decoded_t next_op;

    // Bank address is the register plus 16 times the channel
    function automatic logic [fcore_pkg::bank_addr_bits-1:0] expand(
        input logic [fcore_pkg::channel_bits-1:0] channel,
        input logic [fcore_pkg::reg_bits-1:0] field
    );
        return {channel, field};
    endfunction

    assign opcode = instr.word[3:0];
    assign reg_a = instr.word[7:4];
    assign reg_b = instr.word[11:8];
    assign reg_dest = instr.word[15:12];
    assign imm = instr.word[fcore_pkg::instr_width-1 -: fcore_pkg::imm_bits];

    always_comb begin
        next_op.is_load = 1'b0;
        next_op.alu_op = fcore_pkg::alu_add;
        next_op.addr_a = expand(instr.channel, reg_a);
        next_op.addr_b = expand(instr.channel, reg_b);
        next_op.addr_dest = expand(instr.channel, reg_dest);
        next_op.imm = fcore_pkg::data_width'(imm);
        produces = 1'b1;
        case (opcode)
            fcore_pkg::op_add:  next_op.alu_op = fcore_pkg::alu_add;
            fcore_pkg::op_sub:  next_op.alu_op = fcore_pkg::alu_sub;
            fcore_pkg::op_land: next_op.alu_op = fcore_pkg::alu_and;
            fcore_pkg::op_lor:  next_op.alu_op = fcore_pkg::alu_or;
            fcore_pkg::op_lxor: next_op.alu_op = fcore_pkg::alu_xor;
            fcore_pkg::op_bgt:  next_op.alu_op = fcore_pkg::alu_cmp_gt;
            fcore_pkg::op_beq:  next_op.alu_op = fcore_pkg::alu_cmp_eq;
            fcore_pkg::op_ldr:  next_op.is_load = 1'b1;
            fcore_pkg::op_nop, fcore_pkg::op_stop: produces = 1'b0;
            default: produces = 1'b0;
        endcase
    end

    // No pops once stopped, and none without room in the decoded queue
    assign instr_pop = instr_valid && !core_stop && (credit_count != '0);
    assign consume = instr_pop && produces;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credit_count <= count_t'(fcore_pkg::decoded_depth);
            decoded_push <= 1'b0;
            core_stop <= 1'b0;
        end else begin
            // Credit is taken at pop time, one cycle ahead of the push
            credit_count <= credit_count - count_t'(consume) + count_t'(decoded_credit);
            decoded_push <= consume;
            if (instr_pop && opcode == fcore_pkg::op_stop) begin
                core_stop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (consume) begin
            decoded <= next_op;
        end
    end

endmodule

/* logic/operand_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand fetcher
// Reads both ALU operands through the shared bank, writes
// LDR immediates, and issues operations against output credit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module operand_fetch (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  op_valid,
    input  fcore_pkg::decoded_t                   op,
    input  logic                                  bank_grant,
    input  logic [fcore_pkg::data_width-1:0]      bank_rdata,
    input  logic                                  issue_credit,
    output logic                                  op_pop,
    output logic                                  bank_req,
    output logic                                  bank_write,
    output logic [fcore_pkg::bank_addr_bits-1:0]  bank_addr,
    output logic [fcore_pkg::data_width-1:0]      bank_wdata,
    output logic                                  issue_valid,
    output fcore_pkg::alu_op_t                    issue_op,
    output logic [fcore_pkg::data_width-1:0]      issue_a,
    output logic [fcore_pkg::data_width-1:0]      issue_b,
    output logic [fcore_pkg::bank_addr_bits-1:0]  issue_dest
);

    typedef enum logic [2:0] {
        st_idle,
        st_read_a,
        st_read_b,
        st_issue,
        st_write
    } state_t;

    typedef logic [$clog2(fcore_pkg::issue_credits+1)-1:0] count_t;

    state_t state;
    fcore_pkg::decoded_t cur;
    logic [fcore_pkg::data_width-1:0] opnd_a;
    logic [fcore_pkg::data_width-1:0] opnd_b;
    logic rdata_pending;
    count_t credit_count;
    logic fire;

    assign op_pop = (state == st_idle) && op_valid;
    assign bank_req = (state == st_read_a) || (state == st_read_b) || (state == st_write);
    assign bank_write = state == st_write;
    assign bank_wdata = cur.imm;

    // LDR keeps its destination in the a field
    assign bank_addr = (state == st_read_b) ? cur.addr_b : cur.addr_a;

    // Issue waits until operand b has landed in its register
    assign fire = (state == st_issue) && !rdata_pending && (credit_count != '0);
    assign issue_valid = fire;
    assign issue_op = cur.alu_op;
    assign issue_a = opnd_a;
    assign issue_b = opnd_b;
    assign issue_dest = cur.addr_dest;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            rdata_pending <= 1'b0;
            credit_count <= count_t'(fcore_pkg::issue_credits);
        end else begin
            rdata_pending <= bank_grant && !bank_write;
            credit_count <= credit_count - count_t'(fire) + count_t'(issue_credit);
            case (state)
                st_idle: begin
                    if (op_valid) begin
                        state <= op.is_load ? st_write : st_read_a;
                    end
                end
                st_read_a: if (bank_grant) state <= st_read_b;
                st_read_b: if (bank_grant) state <= st_issue;
                st_issue: if (fire) state <= st_idle;
                st_write: if (bank_grant) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (op_pop) begin
            cur <= op;
        end
        if (rdata_pending && state == st_read_b) begin
            opnd_a <= bank_rdata;
        end
        if (rdata_pending && state == st_issue) begin
            opnd_b <= bank_rdata;
        end
    end

endmodule

/* logic/register_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port register bank shared by all channels
// Fixed-priority arbiter, writeback ahead of the fetcher
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module register_bank (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  wb_valid,
    input  logic [fcore_pkg::bank_addr_bits-1:0]  wb_addr,
    input  logic [fcore_pkg::data_width-1:0]      wb_data,
    input  logic                                  fetch_req,
    input  logic                                  fetch_write,
    input  logic [fcore_pkg::bank_addr_bits-1:0]  fetch_addr,
    input  logic [fcore_pkg::data_width-1:0]      fetch_wdata,
    output logic                                  fetch_grant,
    output logic [fcore_pkg::data_width-1:0]      fetch_rdata
);

    logic [fcore_pkg::data_width-1:0] mem [2**fcore_pkg::bank_addr_bits];

    // Writeback always wins the port
    assign fetch_grant = fetch_req && !wb_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**fcore_pkg::bank_addr_bits; i++) begin
                mem[i] <= '0;
            end
        end else if (wb_valid) begin
            mem[wb_addr] <= wb_data;
        end else if (fetch_grant && fetch_write) begin
            mem[fetch_addr] <= fetch_wdata;
        end
    end

    // Read data follows the grant by one cycle
    always_ff @(posedge clock) begin
        if (fetch_grant && !fetch_write) begin
            fetch_rdata <= mem[fetch_addr];
        end
    end

endmodule

/* logic/fcore_issue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue front end top level
// Instruction queue, decoder, decoded queue, operand fetcher
// and the shared register bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_issue (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  instr_push,
    input  logic [fcore_pkg::instr_width-1:0]     instr_word,
    input  logic [fcore_pkg::channel_bits-1:0]    instr_channel,
    input  logic                                  issue_credit,
    input  logic                                  wb_valid,
    input  logic [fcore_pkg::bank_addr_bits-1:0]  wb_addr,
    input  logic [fcore_pkg::data_width-1:0]      wb_data,
    output logic                                  instr_credit,
    output logic                                  issue_valid,
    output fcore_pkg::alu_op_t                    issue_op,
    output logic [fcore_pkg::data_width-1:0]      issue_a,
    output logic [fcore_pkg::data_width-1:0]      issue_b,
    output logic [fcore_pkg::bank_addr_bits-1:0]  issue_dest,
    output logic                                  core_stop
);

    fcore_pkg::instr_t instr_in;
    fcore_pkg::instr_t queued_instr;
    logic queued_valid;
    logic instr_pop;
    fcore_pkg::decoded_t decoded;
    fcore_pkg::decoded_t fetch_op;
    logic decoded_push;
    logic decoded_credit;
    logic fetch_valid;
    logic fetch_pop;
    logic bank_req;
    logic bank_write;
    logic bank_grant;
    logic [fcore_pkg::bank_addr_bits-1:0] bank_addr;
    logic [fcore_pkg::data_width-1:0] bank_wdata;
    logic [fcore_pkg::data_width-1:0] bank_rdata;

    assign instr_in = '{word: instr_word, channel: instr_channel};

    credit_fifo #(
        .payload_t (fcore_pkg::instr_t),
        .depth     (fcore_pkg::instr_credits)
    ) input_queue_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (instr_push),
        .push_data (instr_in),
        .pop       (instr_pop),
        .pop_valid (queued_valid),
        .pop_data  (queued_instr),
        .credit    (instr_credit)
    );

    fcore_decoder fcore_decoder_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .instr_valid    (queued_valid),
        .instr          (queued_instr),
        .decoded_credit (decoded_credit),
        .instr_pop      (instr_pop),
        .decoded_push   (decoded_push),
        .decoded        (decoded),
        .core_stop      (core_stop)
    );

    credit_fifo #(
        .payload_t (fcore_pkg::decoded_t),
        .depth     (fcore_pkg::decoded_depth)
    ) decoded_queue_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (decoded_push),
        .push_data (decoded),
        .pop       (fetch_pop),
        .pop_valid (fetch_valid),
        .pop_data  (fetch_op),
        .credit    (decoded_credit)
    );

    operand_fetch operand_fetch_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .op_valid     (fetch_valid),
        .op           (fetch_op),
        .bank_grant   (bank_grant),
        .bank_rdata   (bank_rdata),
        .issue_credit (issue_credit),
        .op_pop       (fetch_pop),
        .bank_req     (bank_req),
        .bank_write   (bank_write),
        .bank_addr    (bank_addr),
        .bank_wdata   (bank_wdata),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_dest   (issue_dest)
    );

    register_bank register_bank_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .fetch_req   (bank_req),
        .fetch_write (bank_write),
        .fetch_addr  (bank_addr),
        .fetch_wdata (bank_wdata),
        .fetch_grant (bank_grant),
        .fetch_rdata (bank_rdata)
    );

endmodule

/* testbench/fcore_issue_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on the credit protocol, reset state and stop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_issue_sva (
    input logic clock,
    input logic arst_n,
    input logic instr_push,
    input logic instr_credit,
    input logic issue_valid,
    input logic issue_credit,
    input logic core_stop
);

    int outstanding;
    int pushes;
    int credits;
    int failures = 0;

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 0;
            pushes <= 0;
            credits <= 0;
        end else begin
            outstanding <= outstanding + int'(issue_valid) - int'(issue_credit);
            pushes <= pushes + int'(instr_push);
            credits <= credits + int'(instr_credit);
        end
    end

    issue_within_credit: assert property (@(posedge clock) disable iff (!arst_n)
        issue_valid |-> outstanding < fcore_pkg::issue_credits)
        else begin
            $error("issue_valid with all output credit outstanding");
            failures++;
        end

    credit_after_push: assert property (@(posedge clock) disable iff (!arst_n)
        instr_credit |-> credits < pushes)
        else begin
            $error("instr_credit pulse without a matching push");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> (!issue_valid && !instr_credit && !core_stop))
        else begin
            $error("outputs active during reset");
            failures++;
        end

    stop_is_sticky: assert property (@(posedge clock) disable iff (!arst_n)
        core_stop |=> core_stop)
        else begin
            $error("core_stop fell without reset");
            failures++;
        end

endmodule

/* testbench/issue_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue checker
// Model register bank, reference prediction of each issue,
// in-order comparison against the DUT outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module issue_checker (
    input logic                clock,
    input logic                arst_n,
    input logic                instr_push,
    input logic [15:0]         instr_word,
    input logic [1:0]          instr_channel,
    input logic                wb_valid,
    input logic [5:0]          wb_addr,
    input logic [15:0]         wb_data,
    input logic                issue_valid,
    input fcore_pkg::alu_op_t  issue_op,
    input logic [15:0]         issue_a,
    input logic [15:0]         issue_b,
    input logic [5:0]          issue_dest
);

    logic [15:0] model [64];
    logic [40:0] exp_q [$];
    int pending = 0;
    int errors = 0;
    int checked = 0;
    bit stopped = 1'b0;
    string test_name = "reset";

    function automatic logic [5:0] bank_addr(input logic [1:0] channel, input logic [3:0] r);
        return 6'(channel * 16 + r);
    endfunction

    // Bit 41 says whether the instruction issues at all
    function automatic logic [41:0] predict(input logic [15:0] word, input logic [1:0] channel);
        logic hit;
        logic [2:0] code;
        hit = 1'b1;
        code = 3'd0;
        case (word[3:0])
            fcore_pkg::op_add:  code = 3'(fcore_pkg::alu_add);
            fcore_pkg::op_sub:  code = 3'(fcore_pkg::alu_sub);
            fcore_pkg::op_land: code = 3'(fcore_pkg::alu_and);
            fcore_pkg::op_lor:  code = 3'(fcore_pkg::alu_or);
            fcore_pkg::op_lxor: code = 3'(fcore_pkg::alu_xor);
            fcore_pkg::op_bgt:  code = 3'(fcore_pkg::alu_cmp_gt);
            fcore_pkg::op_beq:  code = 3'(fcore_pkg::alu_cmp_eq);
            default: hit = 1'b0;
        endcase
        return {hit, code, model[bank_addr(channel, word[7:4])],
                model[bank_addr(channel, word[11:8])], bank_addr(channel, word[15:12])};
    endfunction

    task automatic compare_field(input string field, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s issue %0d %s expected %h actual %h", test_name, checked,
                     field, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clock) begin : watch
        logic [41:0] p;
        logic [40:0] e;
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                model[i] = '0;
            end
            exp_q.delete();
            stopped = 1'b0;
        end else begin
            if (wb_valid) begin
                model[wb_addr] = wb_data;
            end
            if (issue_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected issue to dest %h in test %s", issue_dest, test_name);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    compare_field("op", 16'(e[40:38]), 16'(issue_op));
                    compare_field("a", e[37:22], issue_a);
                    compare_field("b", e[21:6], issue_b);
                    compare_field("dest", 16'(e[5:0]), 16'(issue_dest));
                end
            end
            if (instr_push && !stopped) begin
                if (instr_word[3:0] == fcore_pkg::op_stop) begin
                    stopped = 1'b1;
                end else if (instr_word[3:0] == fcore_pkg::op_ldr) begin
                    model[bank_addr(instr_channel, instr_word[7:4])] = {8'h00, instr_word[15:8]};
                end else begin
                    p = predict(instr_word, instr_channel);
                    if (p[41]) begin
                        exp_q.push_back(p[40:0]);
                    end
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

/* testbench/fcore_issue_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the issue front end
// Clock, reset, producer and consumer credit handling
// Five directed and random tests, timeout and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_issue_tb;

    // Instructions pushed over all five tests
    localparam int total_instrs = 56;
    localparam int cycle_limit = total_instrs * 12 + 200;

    logic clock = 1'b0;
    logic arst_n = 1'b0;
    logic instr_push = 1'b0;
    logic [fcore_pkg::instr_width-1:0] instr_word = '0;
    logic [fcore_pkg::channel_bits-1:0] instr_channel = '0;
    logic issue_credit = 1'b0;
    logic wb_valid = 1'b0;
    logic [fcore_pkg::bank_addr_bits-1:0] wb_addr = '0;
    logic [fcore_pkg::data_width-1:0] wb_data = '0;
    logic instr_credit;
    logic issue_valid;
    fcore_pkg::alu_op_t issue_op;
    logic [fcore_pkg::data_width-1:0] issue_a;
    logic [fcore_pkg::data_width-1:0] issue_b;
    logic [fcore_pkg::bank_addr_bits-1:0] issue_dest;
    logic core_stop;

    int seed = 32'h142b;
    int cycles = 0;
    int pushes_total = 0;
    int in_credits_total = 0;
    int issued_total = 0;
    int returned_total = 0;
    bit withhold = 1'b0;
    int tb_errors = 0;
    int errors_before = 0;
    int tests_run = 0;
    string test_name = "reset";

    fcore_issue fcore_issue_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .instr_push    (instr_push),
        .instr_word    (instr_word),
        .instr_channel (instr_channel),
        .issue_credit  (issue_credit),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .instr_credit  (instr_credit),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_dest    (issue_dest),
        .core_stop     (core_stop)
    );

    issue_checker issue_checker_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .instr_push    (instr_push),
        .instr_word    (instr_word),
        .instr_channel (instr_channel),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_dest    (issue_dest)
    );

    bind fcore_issue fcore_issue_sva fcore_issue_sva_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_push   (instr_push),
        .instr_credit (instr_credit),
        .issue_valid  (issue_valid),
        .issue_credit (issue_credit),
        .core_stop    (core_stop)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (instr_credit) begin
            in_credits_total++;
        end
        if (issue_valid) begin
            issued_total++;
        end
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycles, test_name);
            $display("Errors found");
            $finish;
        end
    end

    // The consumer retires each operation one cycle after it issues
    always @(negedge clock) begin
        if (!withhold && issued_total > returned_total) begin
            issue_credit <= 1'b1;
            returned_total++;
        end else begin
            issue_credit <= 1'b0;
        end
    end

    function automatic int credit_left();
        return fcore_pkg::instr_credits + in_credits_total - pushes_total;
    endfunction

    // Checker mismatches, testbench failures and assertion failures together
    function automatic int error_count();
        return issue_checker_i.errors + tb_errors
               + fcore_issue_i.fcore_issue_sva_i.failures;
    endfunction

    function automatic logic [15:0] alu_word(input logic [3:0] opcode, input logic [3:0] ra,
                                             input logic [3:0] rb, input logic [3:0] rd);
        return {rd, rb, ra, opcode};
    endfunction

    task automatic try_push(input logic [15:0] word, input logic [1:0] channel,
                            output bit ok);
        int waited;
        waited = 0;
        while (credit_left() == 0 && waited < 30) begin
            @(negedge clock);
            waited++;
        end
        ok = credit_left() != 0;
        if (ok) begin
            instr_push = 1'b1;
            instr_word = word;
            instr_channel = channel;
            pushes_total++;
            @(negedge clock);
            instr_push = 1'b0;
        end
    endtask

    task automatic push(input logic [15:0] word, input logic [1:0] channel);
        bit ok;
        try_push(word, channel, ok);
        if (!ok) begin
            $display("Input credit did not return in test %s", test_name);
            tb_errors++;
        end
    endtask

    task automatic write_back(input logic [5:0] addr, input logic [15:0] data);
        wb_valid = 1'b1;
        wb_addr = addr;
        wb_data = data;
        @(negedge clock);
        wb_valid = 1'b0;
    endtask

    // Waits until every expected operation issued and the fetcher went quiet
    task automatic drain();
        while (issue_checker_i.pending != 0) begin
            @(negedge clock);
        end
        repeat (8) @(negedge clock);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        issue_checker_i.test_name = name;
        errors_before = error_count();
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name,
                 error_count() - errors_before);
    endtask

    task automatic test_ldr_add_sub();
        logic [31:0] r;
        start_test("ldr_add_sub");
        for (int ch = 0; ch < 4; ch++) begin
            r = $random(seed);
            push({r[15:8], r[3:0], fcore_pkg::op_ldr}, 2'(ch));
            push({r[23:16], r[7:4], fcore_pkg::op_ldr}, 2'(ch));
            push(alu_word(fcore_pkg::op_add, r[3:0], r[7:4], r[27:24]), 2'(ch));
            push(alu_word(fcore_pkg::op_sub, r[7:4], r[3:0], r[31:28]), 2'(ch));
        end
        drain();
        end_test();
    endtask

    task automatic test_logic_compare();
        logic [31:0] r;
        start_test("logic_compare");
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            push(alu_word(4'(fcore_pkg::op_land + 4'(i % 5)), r[3:0], r[7:4], r[11:8]),
                 r[13:12]);
        end
        drain();
        end_test();
    endtask

    task automatic test_writeback();
        logic [31:0] r;
        start_test("writeback");
        for (int burst = 0; burst < 3; burst++) begin
            r = $random(seed);
            write_back({r[1:0], r[5:2]}, r[31:16]);
            write_back({r[1:0], r[9:6]}, {r[15:10], r[31:22]});
            push(alu_word(fcore_pkg::op_add, r[5:2], r[9:6], r[13:10]), r[1:0]);
            push(alu_word(fcore_pkg::op_sub, r[9:6], r[5:2], r[13:10]), r[1:0]);
            push(alu_word(fcore_pkg::op_lxor, r[5:2], r[9:6], r[5:2]), r[1:0]);
            push(alu_word(fcore_pkg::op_beq, r[5:2], r[5:2], r[9:6]), r[1:0]);
            drain();
        end
        end_test();
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        int issued_before;
        int count;
        bit ok;
        bit stalled;
        start_test("backpressure");
        withhold = 1'b1;
        issued_before = issued_total;
        stalled = 1'b0;
        count = 0;
        while (count < 12 && !stalled) begin
            r = $random(seed);
            try_push(alu_word(fcore_pkg::op_add + 4'(r[0]), r[7:4], r[11:8], r[15:12]),
                     r[17:16], ok);
            if (ok) begin
                count++;
            end else begin
                stalled = 1'b1;
            end
        end
        if (issued_total - issued_before > fcore_pkg::issue_credits) begin
            $display("More than %0d operations issued without credit in test %s",
                     fcore_pkg::issue_credits, test_name);
            tb_errors++;
        end
        if (!stalled) begin
            $display("Input credit kept returning while output credit was withheld");
            tb_errors++;
        end
        withhold = 1'b0;
        while (count < 12) begin
            r = $random(seed);
            push(alu_word(fcore_pkg::op_lor, r[7:4], r[11:8], r[15:12]), r[17:16]);
            count++;
        end
        drain();
        end_test();
    endtask

    task automatic test_stop();
        start_test("stop");
        push(alu_word(fcore_pkg::op_nop, 4'd1, 4'd2, 4'd3), 2'd0);
        push(alu_word(4'd9, 4'd1, 4'd2, 4'd3), 2'd1);
        push(alu_word(4'd13, 4'd4, 4'd5, 4'd6), 2'd2);
        push(alu_word(fcore_pkg::op_add, 4'd1, 4'd2, 4'd3), 2'd3);
        push(alu_word(fcore_pkg::op_stop, 4'd0, 4'd0, 4'd0), 2'd0);
        push(alu_word(fcore_pkg::op_add, 4'd4, 4'd5, 4'd6), 2'd1);
        drain();
        repeat (20) @(negedge clock);
        if (core_stop !== 1'b1) begin
            $display("core_stop did not rise after STOP");
            tb_errors++;
        end
        end_test();
    endtask

    initial begin
        int total_errors;
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        test_ldr_add_sub();
        test_logic_compare();
        test_writeback();
        test_backpressure();
        test_stop();
        if (issue_checker_i.pending != 0) begin
            $display("%0d expected operations never issued", issue_checker_i.pending);
            tb_errors++;
        end
        total_errors = error_count();
        $display("Summary: %0d tests, %0d issues checked, %0d errors", tests_run,
                 issue_checker_i.checked, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/fcore_pkg.sv
logic/credit_fifo.sv
logic/fcore_decoder.sv
logic/operand_fetch.sv
logic/register_bank.sv
logic/fcore_issue.sv
testbench/fcore_issue_sva.sv
testbench/issue_checker.sv
testbench/fcore_issue_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the issue front end simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module fcore_issue_tb -o fcore_issue_sim
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/fcore_issue_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
